// ==== src/alu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared definitions of the simd alu
// datapath widths, lane constants, operation and mode encodings,
// operand and lane mask types
//////////////////////////////////////////////////////////////////////

package alu_pkg;

  // datapath geometry
  localparam int DATA_W    = 32;
  localparam int LANE_W    = 8;                 // one byte per lane
  localparam int NUM_LANES = DATA_W / LANE_W;   // 4 byte lanes

  typedef logic [DATA_W-1:0]    word_t;         // operand or result word
  typedef logic [NUM_LANES-1:0] lane_mask_t;    // one bit per byte lane

  // operation codes
  typedef enum logic [4:0] {
    ALU_NOP  = 5'd0,
    ALU_ADD,
    ALU_ADDC,                                   // add with carry_i into lane 0
    ALU_SUB,
    ALU_AVG,                                    // signed average
    ALU_AVGU,                                   // unsigned average
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_EQ,
    ALU_NE,
    ALU_GTS,
    ALU_GTU,
    ALU_GES,
    ALU_GEU,
    ALU_LTS,
    ALU_LTU,
    ALU_LES,
    ALU_LEU,
    ALU_MIN,
    ALU_MINU,
    ALU_MAX,
    ALU_MAXU
  } alu_op_e;

  // element size, code 2'b01 is handled as a full word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // compare flag source, code 2'b11 gives flag 0
  typedef enum logic [1:0] {
    CMP_FULL = 2'b00,                           // lane 0 of the mask
    CMP_ANY  = 2'b01,
    CMP_ALL  = 2'b10
  } cmp_mode_e;

endpackage

// ==== src/alu_add_if.sv ====
//////////////////////////////////////////////////////////////////////
// adder result bundle
// sum, average, lane carries and top element overflow
//////////////////////////////////////////////////////////////////////

interface alu_add_if;

  import alu_pkg::*;

  word_t      sum;          // per element modular sum
  word_t      avg;          // sum shifted right inside each element
  lane_mask_t carry_out;    // carry out of every byte slice
  logic       ovf;          // signed overflow of the top element

  // adder side
  modport source (output sum, avg, carry_out, ovf);

  // result stage side
  modport sink   (input  sum, avg, carry_out, ovf);

endinterface

// ==== src/alu_cmp_if.sv ====
//////////////////////////////////////////////////////////////////////
// comparator result bundle
// per lane equal and greater bits plus the predicate mask
//////////////////////////////////////////////////////////////////////

interface alu_cmp_if;

  import alu_pkg::*;

  lane_mask_t is_equal;     // replicated over each element
  lane_mask_t is_greater;   // signed or unsigned by operator
  lane_mask_t cmp_mask;     // predicate result per lane

  // comparator side
  modport source (output is_equal, is_greater, cmp_mask);

  // result stage side
  modport sink   (input  is_equal, is_greater, cmp_mask);

endinterface

// ==== src/simd_adder.sv ====
//////////////////////////////////////////////////////////////////////
// lane sliced adder for add, addc, sub and averaging
// four byte slices with carry chaining inside each vector element
//////////////////////////////////////////////////////////////////////

module simd_adder
(
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::word_t     operand_a_i,
  input  alu_pkg::word_t     operand_b_i,
  input  logic               carry_i,
  input  alu_pkg::vec_mode_e vector_mode_i,
  alu_add_if.source          add_o
);

  import alu_pkg::*;

  lane_mask_t elem_top;     // lanes holding an element msb
  lane_mask_t elem_base;    // lanes holding an element lsb
  lane_mask_t carry_in;
  lane_mask_t carry_out;
  logic       is_sub;
  logic       chain;        // running carry between slices
  word_t      op_b;         // b inverted for subtract
  word_t      sum;
  word_t      sum_shr;      // whole word shifted right by one
  word_t      avg;

  always_comb
  begin
    case (vector_mode_i)
      VEC_MODE16: elem_top = 4'b1010;
      VEC_MODE8:  elem_top = 4'b1111;
      default:    elem_top = 4'b1000;   // full word
    endcase
  end

  // an element starts right above the top of the one below
  assign elem_base = {elem_top[NUM_LANES-2:0], 1'b1};

  assign is_sub = (operator_i == ALU_SUB);
  assign op_b   = is_sub ? ~operand_b_i : operand_b_i;   // a + ~b + 1

  //////////////////////////////////////////////////////////////////////
  // byte slices
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    chain     = 1'b0;
    carry_in  = '0;
    carry_out = '0;
    sum       = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      carry_in[i] = elem_base[i] ? is_sub : chain;   // break chain at base
      if ((i == 0) && (operator_i == ALU_ADDC))
        carry_in[i] = carry_i;                       // external carry into lane 0 only
      {chain, sum[i*LANE_W +: LANE_W]} = operand_a_i[i*LANE_W +: LANE_W]
                                         + op_b[i*LANE_W +: LANE_W] + carry_in[i];
      carry_out[i] = chain;
    end
  end

  // averaging refills the msb of each element by sign or zero
  assign sum_shr = {1'b0, sum[DATA_W-1:1]};

  always_comb
  begin
    avg = sum_shr;   // lower lane msbs pull in the next lane's lsb
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (elem_top[i])
        avg[i*LANE_W + LANE_W-1] = (operator_i == ALU_AVGU) ? 1'b0 : sum[i*LANE_W + LANE_W-1];
    end
  end

  assign add_o.sum       = sum;
  assign add_o.avg       = avg;
  assign add_o.carry_out = carry_out;
  // overflow of the top element when same sign in gives other sign out
  assign add_o.ovf       = (operand_a_i[DATA_W-1] ^ sum[DATA_W-1])
                         & (op_b[DATA_W-1] ^ sum[DATA_W-1]);

  // a slice that starts an element by the mode sums as if nothing came from below
  always_comb
  begin
    for (int i = 1; i < NUM_LANES; i++)
    begin
      if ((vector_mode_i == VEC_MODE8) || ((vector_mode_i == VEC_MODE16) && (i == 2)))
        assert (sum[i*LANE_W +: LANE_W] == LANE_W'(operand_a_i[i*LANE_W +: LANE_W]
                                                  + op_b[i*LANE_W +: LANE_W] + is_sub))
          else $error("carry chained into an element base lane");
    end
  end

endmodule

// ==== src/simd_comparator.sv ====
//////////////////////////////////////////////////////////////////////
// vector comparator
// byte equal and greater detectors, merge to element width,
// compare predicate mask
//////////////////////////////////////////////////////////////////////

module simd_comparator
(
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::word_t     operand_a_i,
  input  alu_pkg::word_t     operand_b_i,
  input  alu_pkg::vec_mode_e vector_mode_i,
  alu_cmp_if.source          cmp_o
);

  import alu_pkg::*;

  logic       signed_op;
  lane_mask_t elem_top;     // lanes holding an element msb
  lane_mask_t sign_mode;    // lanes compared as signed bytes
  lane_mask_t eq_lane;      // raw byte results
  lane_mask_t gt_lane;
  lane_mask_t is_equal;     // merged, replicated per element
  lane_mask_t is_greater;
  lane_mask_t cmp_mask;

  always_comb
  begin
    case (operator_i)
      ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
      ALU_MIN, ALU_MAX: signed_op = 1'b1;
      default:          signed_op = 1'b0;
    endcase
  end

  always_comb
  begin
    case (vector_mode_i)
      VEC_MODE16: elem_top = 4'b1010;
      VEC_MODE8:  elem_top = 4'b1111;
      default:    elem_top = 4'b1000;
    endcase
  end

  // only the top byte of an element carries the sign
  assign sign_mode = elem_top & {NUM_LANES{signed_op}};

  //////////////////////////////////////////////////////////////////////
  // byte detectors
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    logic [LANE_W-1:0] a_byte;
    logic [LANE_W-1:0] b_byte;

    assign a_byte     = operand_a_i[i*LANE_W +: LANE_W];
    assign b_byte     = operand_b_i[i*LANE_W +: LANE_W];
    assign eq_lane[i] = (a_byte == b_byte);
    // 9 bit compare, extra msb is the sign when signed else 0
    assign gt_lane[i] = $signed({sign_mode[i] & a_byte[LANE_W-1], a_byte})
                      > $signed({sign_mode[i] & b_byte[LANE_W-1], b_byte});
  end

  // upper byte decides, lower byte only on a tie
  always_comb
  begin
    case (vector_mode_i)
      VEC_MODE8:
      begin
        is_equal   = eq_lane;
        is_greater = gt_lane;
      end
      VEC_MODE16:
      begin
        is_equal[1:0]   = {2{&eq_lane[1:0]}};
        is_equal[3:2]   = {2{&eq_lane[3:2]}};
        is_greater[1:0] = {2{gt_lane[1] | (eq_lane[1] & gt_lane[0])}};
        is_greater[3:2] = {2{gt_lane[3] | (eq_lane[3] & gt_lane[2])}};
      end
      default:
      begin
        is_equal   = {NUM_LANES{&eq_lane}};
        is_greater = {NUM_LANES{gt_lane[3] | (eq_lane[3] & (gt_lane[2]
                                           | (eq_lane[2] & (gt_lane[1]
                                           | (eq_lane[1] & gt_lane[0])))))}};
      end
    endcase
  end

  // predicate
  always_comb
  begin
    case (operator_i)
      ALU_NE:           cmp_mask = ~is_equal;
      ALU_GTS, ALU_GTU: cmp_mask = is_greater;
      ALU_GES, ALU_GEU: cmp_mask = is_greater | is_equal;
      ALU_LTS, ALU_LTU: cmp_mask = ~(is_greater | is_equal);
      ALU_LES, ALU_LEU: cmp_mask = ~is_greater;
      default:          cmp_mask = is_equal;   // eq and non compares
    endcase
  end

  assign cmp_o.is_equal   = is_equal;
  assign cmp_o.is_greater = is_greater;
  assign cmp_o.cmp_mask   = cmp_mask;

  // merged results stay exclusive in every lane
  always_comb
  begin
    assert ((is_equal & is_greater) == '0)
      else $error("lane both equal and greater");
  end

endmodule

// ==== src/alu_result_stage.sv ====
//////////////////////////////////////////////////////////////////////
// alu result stage
// min/max lane mux, logic ops, result mux and output register
//////////////////////////////////////////////////////////////////////

module alu_result_stage
(
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::word_t     operand_a_i,
  input  alu_pkg::word_t     operand_b_i,
  input  alu_pkg::cmp_mode_e cmp_mode_i,
  alu_add_if.sink            add_i,
  alu_cmp_if.sink            cmp_i,
  output alu_pkg::word_t     result_o,
  output logic               carry_o,
  output logic               overflow_o,
  output logic               flag_o,
  output logic               valid_o
);

  import alu_pkg::*;

  logic       do_min;
  lane_mask_t sel_a;        // lane takes operand a
  word_t      minmax;
  word_t      cmp_bytes;    // mask spread to full bytes
  word_t      result_d;
  logic       carry_d;
  logic       ovf_d;
  logic       flag_d;

  assign do_min = (operator_i == ALU_MIN) || (operator_i == ALU_MINU);
  assign sel_a  = cmp_i.is_greater ^ {NUM_LANES{do_min}};   // max keeps greater a

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    assign minmax[i*LANE_W +: LANE_W]    = sel_a[i] ? operand_a_i[i*LANE_W +: LANE_W]
                                                    : operand_b_i[i*LANE_W +: LANE_W];
    assign cmp_bytes[i*LANE_W +: LANE_W] = {LANE_W{cmp_i.cmp_mask[i]}};
  end

  //////////////////////////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    result_d = '0;
    carry_d  = 1'b0;   // carry and overflow only from add, addc, sub
    ovf_d    = 1'b0;
    flag_d   = 1'b0;
    case (operator_i)
      ALU_ADD, ALU_ADDC, ALU_SUB:
      begin
        result_d = add_i.sum;
        carry_d  = add_i.carry_out[NUM_LANES-1];
        ovf_d    = add_i.ovf;
      end
      ALU_AVG, ALU_AVGU: result_d = add_i.avg;
      ALU_AND:           result_d = operand_a_i & operand_b_i;
      ALU_OR:            result_d = operand_a_i | operand_b_i;
      ALU_XOR:           result_d = operand_a_i ^ operand_b_i;
      ALU_MIN, ALU_MINU,
      ALU_MAX, ALU_MAXU: result_d = minmax;
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU:
      begin
        result_d = cmp_bytes;
        case (cmp_mode_i)
          CMP_FULL: flag_d = cmp_i.cmp_mask[0];
          CMP_ANY:  flag_d = |cmp_i.cmp_mask;
          CMP_ALL:  flag_d = &cmp_i.cmp_mask;
          default:  flag_d = 1'b0;
        endcase
      end
      default: ;   // nop gives zero
    endcase
  end

  // one stage that holds its data while idle
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_o    <= 1'b0;
      result_o   <= '0;
      carry_o    <= 1'b0;
      overflow_o <= 1'b0;
      flag_o     <= 1'b0;
    end
    else
    begin
      valid_o <= valid_i;
      if (valid_i)
      begin
        result_o   <= result_d;
        carry_o    <= carry_d;
        overflow_o <= ovf_d;
        flag_o     <= flag_d;
      end
    end
  end

  // nothing leaves the stage on the first edge out of reset
  a_valid_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !valid_o);

  // min and max may pick either operand on a tie since equal lanes hold the same byte
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_equal_chk
    a_equal_lane: assert property (@(posedge clk) disable iff (!rst_n_i)
      cmp_i.is_equal[i]
        |-> (operand_a_i[i*LANE_W +: LANE_W] == operand_b_i[i*LANE_W +: LANE_W]));
  end

endmodule

// ==== src/alu_simd.sv ====
//////////////////////////////////////////////////////////////////////
// simd alu top level
// adder and comparator feeding the registered result stage
//////////////////////////////////////////////////////////////////////

module alu_simd
(
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               valid_i,         // operation strobe, no stall
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::word_t     operand_a_i,
  input  alu_pkg::word_t     operand_b_i,
  input  logic               carry_i,         // addc carry into lane 0
  input  alu_pkg::vec_mode_e vector_mode_i,
  input  alu_pkg::cmp_mode_e cmp_mode_i,
  output alu_pkg::word_t     result_o,
  output logic               carry_o,
  output logic               overflow_o,
  output logic               flag_o,
  output logic               valid_o          // one cycle after valid_i
);

  alu_add_if add_bus ();   // adder to result stage
  alu_cmp_if cmp_bus ();   // comparator to result stage

  // arithmetic and averaging
  simd_adder u_adder
  (
    .operator_i    (operator_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .carry_i       (carry_i),
    .vector_mode_i (vector_mode_i),
    .add_o         (add_bus.source)
  );

  // compares, also drives the min/max select
  simd_comparator u_cmp
  (
    .operator_i    (operator_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .vector_mode_i (vector_mode_i),
    .cmp_o         (cmp_bus.source)
  );

  alu_result_stage u_result
  (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .cmp_mode_i  (cmp_mode_i),
    .add_i       (add_bus.sink),
    .cmp_i       (cmp_bus.sink),
    .result_o    (result_o),
    .carry_o     (carry_o),
    .overflow_o  (overflow_o),
    .flag_o      (flag_o),
    .valid_o     (valid_o)
  );

endmodule

// ==== tb/alu_ref_model.svh ====
//////////////////////////////////////////////////////////////////////
// reference model of the simd alu
// predicted output record, compare predicate, per element prediction
//////////////////////////////////////////////////////////////////////

`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// expected registered outputs of one operation
typedef struct packed {
  word_t result;
  logic  carry;
  logic  ovf;
  logic  flag;
} pred_t;

// predicate of one element
function automatic logic cmp_hit(input alu_op_e op, input logic gt, input logic eq);
  case (op)
    ALU_EQ:           return eq;
    ALU_NE:           return !eq;
    ALU_GTS, ALU_GTU: return gt;
    ALU_GES, ALU_GEU: return gt || eq;
    ALU_LTS, ALU_LTU: return !(gt || eq);
    ALU_LES, ALU_LEU: return !gt;
    default:          return 1'b0;
  endcase
endfunction

function automatic pred_t predict(input alu_op_e op, input word_t a, input word_t b,
                                  input logic cin, input vec_mode_e vmode,
                                  input cmp_mode_e cmode);
  pred_t       p;
  int          w;            // element width in bits
  logic [63:0] msk;
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] bb;           // b, inverted for subtract
  logic [63:0] s;            // element sum with carry out
  logic [63:0] r;            // element result
  logic        sgn;
  logic        gt;
  logic        eq;
  logic        hit;
  lane_mask_t  mask;

  p    = '0;
  mask = '0;
  case (vmode)
    VEC_MODE16: w = 16;
    VEC_MODE8:  w = 8;
    default:    w = 32;      // spare code too
  endcase
  msk = (64'd1 << w) - 64'd1;
  sgn = (op inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_MIN, ALU_MAX});

  for (int e = 0; e < DATA_W / w; e++)
  begin
    ea = ({32'd0, a} >> (e * w)) & msk;
    eb = ({32'd0, b} >> (e * w)) & msk;
    bb = (op == ALU_SUB) ? (~eb & msk) : eb;
    s  = ea + bb + ((op == ALU_SUB) ? 64'd1 : 64'd0)
            + (((op == ALU_ADDC) && (e == 0)) ? {63'd0, cin} : 64'd0);   // lowest element only
    eq = (ea == eb);
    if (sgn)
      gt = $signed(ea[6'(w-1)] ? (ea | ~msk) : ea) > $signed(eb[6'(w-1)] ? (eb | ~msk) : eb);
    else
      gt = (ea > eb);
    hit = 1'b0;
    case (op)
      ALU_ADD, ALU_ADDC, ALU_SUB: r = s & msk;
      ALU_AVG:  r = ((s & msk) >> 1) | (s & (64'd1 << (w - 1)));   // sum msb stays
      ALU_AVGU: r = (s & msk) >> 1;
      ALU_AND:  r = ea & eb;
      ALU_OR:   r = ea | eb;
      ALU_XOR:  r = ea ^ eb;
      ALU_MIN, ALU_MINU: r = gt ? eb : ea;
      ALU_MAX, ALU_MAXU: r = gt ? ea : eb;
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU:
      begin
        hit = cmp_hit(op, gt, eq);
        r   = hit ? msk : 64'd0;
        for (int l = e * w / LANE_W; l < (e + 1) * w / LANE_W; l++)
          mask[2'(l)] = hit;
      end
      default: r = 64'd0;    // nop
    endcase
    p.result = p.result | word_t'(r << (e * w));
    // carry and overflow of the top element
    if ((e == DATA_W / w - 1) && (op inside {ALU_ADD, ALU_ADDC, ALU_SUB}))
    begin
      p.carry = s[6'(w)];
      p.ovf   = (ea[6'(w-1)] == bb[6'(w-1)]) && (s[6'(w-1)] != ea[6'(w-1)]);
    end
  end

  if (op inside {[ALU_EQ:ALU_LEU]})
  begin
    case (cmode)
      CMP_FULL: p.flag = mask[0];
      CMP_ANY:  p.flag = |mask;
      CMP_ALL:  p.flag = &mask;
      default:  p.flag = 1'b0;
    endcase
  end
  return p;
endfunction

`endif

// ==== tb/tb_alu_simd.sv ====
//////////////////////////////////////////////////////////////////////
// testbench of the simd alu
// clock, reset, random operations, prediction queue, compare tasks
//////////////////////////////////////////////////////////////////////

module tb_alu_simd;

  timeunit 1ns;
  timeprecision 1ps;

  import alu_pkg::*;

  `include "alu_ref_model.svh"

  localparam int NUM_OPS       = 2000;
  localparam int RESET_CYCLES  = 5;
  localparam int DRAIN_TIMEOUT = 20;   // cycles

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      valid_i;
  alu_op_e   operator_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  logic      carry_i;
  vec_mode_e vector_mode_i;
  cmp_mode_e cmp_mode_i;
  word_t     result_o;
  logic      carry_o;
  logic      overflow_o;
  logic      flag_o;
  logic      valid_o;

  integer    seed;
  pred_t     pred_q[$];     // one entry per accepted operation
  logic      exp_valid;     // valid_i of the previous cycle
  int        errors;
  int        ops_sent;
  int        wait_cycles;

  always #2 clk = ~clk;     // 4 ns period

  alu_simd u_dut
  (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .valid_i       (valid_i),
    .operator_i    (operator_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .carry_i       (carry_i),
    .vector_mode_i (vector_mode_i),
    .cmp_mode_i    (cmp_mode_i),
    .result_o      (result_o),
    .carry_o       (carry_o),
    .overflow_o    (overflow_o),
    .flag_o        (flag_o),
    .valid_o       (valid_o)
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "result word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      errors++;
      $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "output bit mismatch");
    end
  endtask

  // new random operation, prediction queued when valid
  task automatic drive_inputs(input logic allow_valid);
    valid_i       = allow_valid && (($random(seed) & 3) != 0);   // about 3 in 4
    operator_i    = alu_op_e'(5'($unsigned($random(seed)) % 23));
    operand_a_i   = $random(seed);
    operand_b_i   = $random(seed);
    if (($random(seed) & 3) == 0)
      operand_b_i = operand_a_i ^ (32'h0000_00ff & $random(seed));   // ties in upper bytes
    carry_i       = 1'($random(seed));
    vector_mode_i = vec_mode_e'(2'($random(seed)));
    cmp_mode_i    = cmp_mode_e'(2'($random(seed)));
    if (valid_i)
    begin
      pred_q.push_back(predict(operator_i, operand_a_i, operand_b_i, carry_i,
                               vector_mode_i, cmp_mode_i));
      ops_sent++;
    end
    exp_valid = valid_i;
  endtask

  // check at the falling edge where outputs are stable, then drive
  task automatic cycle_step(input logic allow_valid);
    pred_t pred;
    @(negedge clk);
    check_bit("valid_o", exp_valid, valid_o);
    if (valid_o)
    begin
      pred = pred_q.pop_front();
      check_word("result_o", pred.result, result_o);
      check_bit("carry_o", pred.carry, carry_o);
      check_bit("overflow_o", pred.ovf, overflow_o);
      check_bit("flag_o", pred.flag, flag_o);
    end
    drive_inputs(allow_valid);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed          = 32'h58e3;
    errors        = 0;
    ops_sent      = 0;
    exp_valid     = 1'b0;
    wait_cycles   = 0;
    rst_n_i       = 1'b0;
    valid_i       = 1'b0;
    operator_i    = ALU_NOP;
    operand_a_i   = '0;
    operand_b_i   = '0;
    carry_i       = 1'b0;
    vector_mode_i = VEC_MODE32;
    cmp_mode_i    = CMP_FULL;

    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge clk);
      check_bit("valid_o", 1'b0, valid_o);
    end
    check_word("result_o", '0, result_o);   // reset values
    check_bit("carry_o", 1'b0, carry_o);
    check_bit("overflow_o", 1'b0, overflow_o);
    check_bit("flag_o", 1'b0, flag_o);
    rst_n_i = 1'b1;

    cycle_step(1'b0);   // first cycle out of reset, nothing issued
    while (ops_sent < NUM_OPS)
      cycle_step(1'b1);

    // drain the last operation
    while (((pred_q.size() != 0) || exp_valid) && (wait_cycles < DRAIN_TIMEOUT))
    begin
      cycle_step(1'b0);
      wait_cycles++;
    end

    if (pred_q.size() != 0)
    begin
      $display("DUT gave no result for %0d pending operations", pred_q.size());
      $display("Checks failed");
      $fatal(1, "timeout waiting for results");
    end
    else if (errors == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("Checks failed");
      $fatal(1, "mismatches found");
    end
  end

endmodule

// ==== project.f ====
+incdir+tb
src/alu_pkg.sv
src/alu_add_if.sv
src/alu_cmp_if.sv
src/simd_adder.sv
src/simd_comparator.sv
src/alu_result_stage.sv
src/alu_simd.sv
tb/tb_alu_simd.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the simd alu testbench with verilator, verdict taken from the log
LOG=sim.log
rm -f "$LOG"
{ verilator --binary --assert -f project.f --top-module tb_alu_simd -o tb_alu_simd \
  && ./obj_dir/tb_alu_simd; } > "$LOG" 2>&1 || echo "build or simulation error" >> "$LOG"
cat "$LOG"
grep -q "Checks failed" "$LOG" && { echo "simulation FAILED"; exit 1; }
grep -q "All checks passed" "$LOG" || { echo "simulation FAILED, no verdict in log"; exit 1; }
echo "simulation PASSED"
